// File: decodeFrontEnd.f
+incdir+include
logic/decodePkg.sv
logic/instStreamIf.sv
logic/FetchUnit.sv
logic/InstructionQueue.sv
logic/InstructionDecoder.sv
logic/IssueStage.sv
logic/DecodeFrontEnd.sv
verif/DecodeFrontEnd_tb.sv

// File: verif/DecodeFrontEnd_tb.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module DecodeFrontEnd_tb;
    localparam int ClkPeriod      = 20;
    localparam int OpcodeWords    = 14;
    localparam int BurstWords     = 60;
    localparam int HaltExtraWords = 6;
    localparam int ParkedWords    = 2;
    localparam int RestartWords   = 4;
    localparam int TotalWords     = OpcodeWords + BurstWords + 1 + HaltExtraWords +
                                    ParkedWords + 1 + RestartWords;
    // 40 cycles per word, plus room for resets and the ack that never comes
    localparam int WatchdogCycles = TotalWords * 40 + 300;

    logic                   clk;
    logic                   rst;
    logic                   instReq;
    logic [`DATA_WIDTH-1:0] instData;
    logic                   instAck;
    logic                   issueReady;
    logic                   issueValid;
    logic [`PC_WIDTH-1:0]   issuePc;
    logic                   halted;
    logic                   dirtyBitTrigger;
    logic [4:0]             funcUnitEnable;
    logic [1:0]             writebackSource;
    logic [3:0]             minorOpcode;
    logic                   immediateEn;
    logic                   upperImmediateEn;
    logic [`DATA_WIDTH-1:0] immediate;
    logic                   regAReadEn;
    logic                   regAWriteEn;
    logic [3:0]             regAAddr;
    logic                   regBReadEn;
    logic [3:0]             regBAddr;
    logic                   branchStall;
    logic                   relativeEn;
    logic [`DATA_WIDTH-1:0] branchOffset;
    logic                   jumpEn;
    logic                   jumpAndLinkEn;
    logic                   haltEn;

    integer                 seed = 48;
    int                     sinkMask;
    logic                   sinkHold;
    logic [`PC_WIDTH-1:0]   nextPc;
    decodePkg::decodedOp_t  expQ[$];
    logic [`PC_WIDTH-1:0]   pcQ[$];
    logic [15:0]            opcodeWords [OpcodeWords] = '{
        16'h0123, 16'h1A5C, 16'h2347, 16'h3F6E, 16'h8C91, 16'h9DF2, 16'hA0B3,
        16'hA48D, 16'hBE2A, 16'hB3C7, 16'hC2FF, 16'hD7A1, 16'hE8B4, 16'hF9C6
    };
    logic [3:0]             legalOps [12] = '{
        4'd0, 4'd1, 4'd2, 4'd3, 4'd8, 4'd9, 4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15
    };
    logic [15:0]            burstWords [BurstWords];

    DecodeFrontEnd uut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired, the run did not finish in time");
        $display("Test failed");
        $fatal(1);
    end

    task automatic failRun(input string why);
        $display("%s at %0t", why, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Expected decode, built from the instruction set rules
    function automatic decodePkg::decodedOp_t decodeRef(input logic [15:0] word);
        decodePkg::decodedOp_t op;
        decodePkg::majorOp_t   major;
        logic                  pcChange;
        op       = '0;
        major    = decodePkg::majorOp_t'(word[15:12]);
        pcChange = word[15] && !word[14];
        // Odd opcodes in the upper half carry a split register A field
        op.regAAddr     = (word[15] && word[12]) ? {word[11:10], 1'b0, word[14]} : word[11:8];
        op.regBAddr     = word[3:0];
        op.relativeEn   = word[12];
        op.branchOffset = {word[7:4], 3'b000};
        op.immediateEn  = (word[15:12] == 4'd9) || (word[15:12] == 4'd11) || (word[15:14] == 2'b11);
        op.minorOpcode  = op.immediateEn ? 4'h7 : word[7:4];
        op.haltEn       = (word[15:12] == 4'd2) && (word[7:4] == 4'hF);
        case (major)
            decodePkg::ALU0, decodePkg::ALU1: begin
                op.regAReadEn      = 1'b1;
                op.regAWriteEn     = 1'b1;
                op.regBReadEn      = 1'b1;
                op.writebackSource = (major == decodePkg::ALU0) ? decodePkg::WB_ALU0_IMM
                                                                : decodePkg::WB_ALU1;
                op.funcUnitEnable  = (major == decodePkg::ALU0) ? 5'b00001 : 5'b00010;
            end
            decodePkg::COMPLEX, decodePkg::MEMORY: begin
                op.regAReadEn      = 1'b1;
                op.regBReadEn      = 1'b1;
                op.funcUnitEnable  = (major == decodePkg::COMPLEX) ? 5'b00100 : 5'b01000;
                op.dirtyBitTrigger = (word[7:6] == 2'b00);
            end
            decodePkg::JAL_REG, decodePkg::JAL_IMM: begin
                op.regAReadEn      = 1'b1;
                op.regAWriteEn     = 1'b1;
                op.regBReadEn      = (major == decodePkg::JAL_REG);
                op.writebackSource = decodePkg::WB_PC_PLUS_ONE;
                op.funcUnitEnable  = 5'b10000;
                op.branchStall     = 1'b1;
                op.jumpAndLinkEn   = 1'b1;
            end
            decodePkg::BRANCH_REG, decodePkg::BRANCH_IMM: begin
                op.regAReadEn     = 1'b1;
                op.regBReadEn     = (major == decodePkg::BRANCH_REG);
                op.branchStall    = (op.regAAddr != 4'd0);
                op.funcUnitEnable = {op.branchStall, 4'b0000};
                op.jumpEn         = !op.branchStall;
            end
            decodePkg::UPPER_IMM: begin
                op.regAReadEn       = 1'b1;
                op.regAWriteEn      = 1'b1;
                op.upperImmediateEn = 1'b1;
                op.writebackSource  = decodePkg::WB_ALU0_IMM;
            end
            decodePkg::IMM0, decodePkg::IMM1, decodePkg::IMM3: begin
                op.regAWriteEn     = 1'b1;
                op.writebackSource = decodePkg::WB_ALU0_IMM;
            end
            default: ;
        endcase
        if (pcChange) begin
            op.immediate = {{6{word[9]}}, word[9:0]};
        end else begin
            case (word[13:12])
                2'b00:   op.immediate = {8'h00, word[7:0]};
                2'b01:   op.immediate = {6'b000000, word[9:0]};
                2'b10:   op.immediate = {word[7:0], 8'h00};
                default: op.immediate = {6'b111111, word[9:0]};
            endcase
        end
        return op;
    endfunction

    task automatic compareIssue(input decodePkg::decodedOp_t exp, input logic [7:0] expPc);
        checkValue("issuePc", issuePc, expPc);
        checkValue("dirtyBitTrigger", dirtyBitTrigger, exp.dirtyBitTrigger);
        checkValue("funcUnitEnable", funcUnitEnable, exp.funcUnitEnable);
        checkValue("writebackSource", writebackSource, exp.writebackSource);
        checkValue("minorOpcode", minorOpcode, exp.minorOpcode);
        checkValue("immediateEn", immediateEn, exp.immediateEn);
        checkValue("upperImmediateEn", upperImmediateEn, exp.upperImmediateEn);
        checkValue("immediate", immediate, exp.immediate);
        checkValue("regAReadEn", regAReadEn, exp.regAReadEn);
        checkValue("regAWriteEn", regAWriteEn, exp.regAWriteEn);
        checkValue("regAAddr", regAAddr, exp.regAAddr);
        checkValue("regBReadEn", regBReadEn, exp.regBReadEn);
        checkValue("regBAddr", regBAddr, exp.regBAddr);
        checkValue("branchStall", branchStall, exp.branchStall);
        checkValue("relativeEn", relativeEn, exp.relativeEn);
        checkValue("branchOffset", branchOffset, exp.branchOffset);
        checkValue("jumpEn", jumpEn, exp.jumpEn);
        checkValue("jumpAndLinkEn", jumpAndLinkEn, exp.jumpAndLinkEn);
        checkValue("haltEn", haltEn, exp.haltEn);
    endtask

    // Called just after a rising edge; values read at an edge are the settled ones
    task automatic sendWord(input logic [15:0] word, input int maxWait, input bit expectIssue,
                            output bit acked, output int waitCycles);
        acked      = 1'b0;
        waitCycles = 0;
        checkValue("instAck before request", instAck, 1'b0);
        instData <= word;
        instReq  <= 1'b1;
        while (!acked && waitCycles < maxWait) begin
            @(posedge clk);
            waitCycles++;
            acked = instAck;
        end
        if (acked) begin
            // First edge after raising the request cannot have seen it
            if (waitCycles < 2) begin
                failRun("instAck rose before instReq was seen");
            end
            if (expectIssue) begin
                expQ.push_back(decodeRef(word));
                pcQ.push_back(nextPc);
            end
            nextPc++;
            instReq <= 1'b0;
            @(posedge clk);
            // Request was still high at the edge before, so the ack holds
            checkValue("instAck before instReq seen low", instAck, 1'b1);
            while (instAck) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic sendChecked(input logic [15:0] word, output int waitCycles);
        bit acked;
        sendWord(word, 200, 1'b1, acked, waitCycles);
        if (!acked) begin
            failRun("instAck never arrived for a word");
        end
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic applyReset();
        expQ.delete();
        pcQ.delete();
        nextPc = '0;
        rst     <= 1'b1;
        instReq <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Sink with random back-pressure
    always @(posedge clk) begin
        issueReady <= !sinkHold && (($random(seed) & sinkMask) == 0);
    end

    // Scoreboard compare on each accepted issue
    always @(posedge clk) begin
        if (!rst && issueValid && issueReady) begin
            if (expQ.size() == 0) begin
                failRun("Issue seen with no word outstanding");
            end else begin
                compareIssue(expQ.pop_front(), pcQ.pop_front());
            end
        end
    end

    initial begin
        int          waitCycles;
        int          delayedAcks;
        int          haltAcks;
        bit          acked;
        logic [31:0] rnd;
        rst        = 1'b1;
        instReq    = 1'b0;
        instData   = '0;
        issueReady = 1'b0;
        sinkMask   = 1;
        sinkHold   = 1'b0;
        nextPc     = '0;
        delayedAcks = 0;
        haltAcks    = 0;
        // Legal non-halt burst, fixed before the clock runs
        for (int i = 0; i < BurstWords; i++) begin
            rnd           = $random(seed);
            burstWords[i] = {legalOps[rnd[31:16] % 12], rnd[11:0]};
            if (burstWords[i][15:12] == 4'd2 && burstWords[i][7:4] == 4'hF) begin
                burstWords[i][7:4] = 4'h3;
            end
        end
        @(posedge clk);
        applyReset();

        for (int i = 0; i < OpcodeWords; i++) begin
            sendChecked(opcodeWords[i], waitCycles);
        end
        waitDrain();

        // Slow sink so the queue fills
        sinkMask <= 7;
        for (int i = 0; i < BurstWords; i++) begin
            sendChecked(burstWords[i], waitCycles);
            if (waitCycles > 2) begin
                delayedAcks++;
            end
        end
        sinkMask <= 1;
        waitDrain();
        if (delayedAcks == 0) begin
            failRun("Back-pressure never delayed instAck during the burst");
        end

        sendChecked(16'h25F3, waitCycles);
        waitDrain();
        checkValue("halted", halted, 1'b1);
        // Holding register plus queue take five more words, then nothing
        for (int i = 0; i < HaltExtraWords; i++) begin
            sendWord(16'h0100 + i, 20, 1'b0, acked, waitCycles);
            if (acked) begin
                haltAcks++;
            end
        end
        checkValue("words acked after halt", haltAcks, 1 + `QUEUE_DEPTH);
        checkValue("issueValid after halt", issueValid, 1'b0);
        checkValue("halted", halted, 1'b1);

        // Reset with the queue full and a request pending
        applyReset();
        @(posedge clk);
        checkValue("halted after reset", halted, 1'b0);

        // Park words at the issue output and leave one mid-handshake
        sinkHold <= 1'b1;
        for (int i = 0; i < ParkedWords; i++) begin
            sendWord(opcodeWords[i], 200, 1'b0, acked, waitCycles);
            if (!acked) begin
                failRun("instAck never arrived for a parked word");
            end
        end
        instData <= opcodeWords[ParkedWords];
        instReq  <= 1'b1;
        waitCycles = 0;
        while (!(instAck && issueValid) && waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        checkValue("instAck before traffic reset", instAck, 1'b1);
        checkValue("issueValid before traffic reset", issueValid, 1'b1);

        applyReset();
        sinkHold <= 1'b0;
        @(posedge clk);
        checkValue("issueValid after reset", issueValid, 1'b0);
        checkValue("instAck after reset", instAck, 1'b0);
        for (int i = 0; i < RestartWords; i++) begin
            sendChecked(opcodeWords[i + 4], waitCycles);
        end
        waitDrain();
        repeat (4) @(posedge clk);

        $display("Test passed");
        $finish;
    end

endmodule

// File: logic/DecodeFrontEnd.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module DecodeFrontEnd (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instReq,
    input  logic [`DATA_WIDTH-1:0] instData,
    output logic                   instAck,
    input  logic                   issueReady,
    output logic                   issueValid,
    output logic [`PC_WIDTH-1:0]   issuePc,
    output logic                   halted,
    output logic                   dirtyBitTrigger,
    output logic [4:0]             funcUnitEnable,
    output logic [1:0]             writebackSource,
    output logic [3:0]             minorOpcode,
    output logic                   immediateEn,
    output logic                   upperImmediateEn,
    output logic [`DATA_WIDTH-1:0] immediate,
    output logic                   regAReadEn,
    output logic                   regAWriteEn,
    output logic [3:0]             regAAddr,
    output logic                   regBReadEn,
    output logic [3:0]             regBAddr,
    output logic                   branchStall,
    output logic                   relativeEn,
    output logic [`DATA_WIDTH-1:0] branchOffset,
    output logic                   jumpEn,
    output logic                   jumpAndLinkEn,
    output logic                   haltEn
);
    decodePkg::decodedOp_t issueOp;

    instStreamIf fetchToQueue ();
    instStreamIf queueToIssue ();

    FetchUnit fetchUnit (
        .clk       (clk),
        .rst       (rst),
        .instReq   (instReq),
        .instData  (instData),
        .instAck   (instAck),
        .outStream (fetchToQueue.producer)
    );

    InstructionQueue instQueue (
        .clk       (clk),
        .rst       (rst),
        .inStream  (fetchToQueue.consumer),
        .outStream (queueToIssue.producer)
    );

    IssueStage issueStage (
        .clk        (clk),
        .rst        (rst),
        .inStream   (queueToIssue.consumer),
        .issueValid (issueValid),
        .issueReady (issueReady),
        .issueOp    (issueOp),
        .issuePc    (issuePc),
        .halted     (halted)
    );

    // Decoded operation fanned out to plain ports
    assign dirtyBitTrigger  = issueOp.dirtyBitTrigger;
    assign funcUnitEnable   = issueOp.funcUnitEnable;
    assign writebackSource  = issueOp.writebackSource;
    assign minorOpcode      = issueOp.minorOpcode;
    assign immediateEn      = issueOp.immediateEn;
    assign upperImmediateEn = issueOp.upperImmediateEn;
    assign immediate        = issueOp.immediate;
    assign regAReadEn       = issueOp.regAReadEn;
    assign regAWriteEn      = issueOp.regAWriteEn;
    assign regAAddr         = issueOp.regAAddr;
    assign regBReadEn       = issueOp.regBReadEn;
    assign regBAddr         = issueOp.regBAddr;
    assign branchStall      = issueOp.branchStall;
    assign relativeEn       = issueOp.relativeEn;
    assign branchOffset     = issueOp.branchOffset;
    assign jumpEn           = issueOp.jumpEn;
    assign jumpAndLinkEn    = issueOp.jumpAndLinkEn;
    assign haltEn           = issueOp.haltEn;

endmodule

// File: logic/IssueStage.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module IssueStage (
    input  logic                  clk,
    input  logic                  rst,
    instStreamIf.consumer         inStream,
    output logic                  issueValid,
    input  logic                  issueReady,
    output decodePkg::decodedOp_t issueOp,
    output logic [`PC_WIDTH-1:0]  issuePc,
    output logic                  halted
);
    decodePkg::decodedOp_t decoded;
    logic                  pop;

    InstructionDecoder decoder (
        .instruction      (inStream.instruction),
        .instructionValid (inStream.valid),
        .decoded          (decoded)
    );

    // Take a word when the output slot is free or emptying, never after halt
    assign inStream.ready = !halted && (!issueValid || issueReady);
    assign pop            = inStream.valid && inStream.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
            halted     <= 1'b0;
        end else begin
            if (pop) begin
                issueValid <= 1'b1;
            end else if (issueReady) begin
                issueValid <= 1'b0;
            end
            // Sticky until reset
            if (pop && decoded.haltEn) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issueOp <= decoded;
            issuePc <= inStream.pc;
        end
    end

    // Output held for the core until it is taken
    issueHeld: assert property (@(posedge clk) disable iff (rst)
        issueValid && !issueReady |=> issueValid && $stable(issueOp) && $stable(issuePc));

endmodule

// File: logic/InstructionDecoder.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module InstructionDecoder (
    input  logic [15:0]           instruction,
    input  logic                  instructionValid,
    output decodePkg::decodedOp_t decoded
);
    decodePkg::majorOp_t    majorOp;
    decodePkg::wbSource_t   wbSrc;
    logic                   upperAddrEn;
    logic [3:0]             regAAddr;
    logic                   regANonZero;
    logic                   dirtyEn;
    logic [4:0]             fuEn;
    logic                   immEn;
    logic                   upperImmEn;
    logic                   regARead;
    logic                   regAWrite;
    logic                   regBRead;
    logic                   stall;
    logic                   jumpAndLink;
    logic                   pcEn;
    logic                   jumpEn;
    logic                   signExtend;
    logic [3:0]             minorOp;
    logic [1:0]             immSelect;
    logic [`DATA_WIDTH-1:0] wideImm;
    logic [`DATA_WIDTH-1:0] immediate;

    assign majorOp = decodePkg::majorOp_t'(instruction[15:12]);

    // Odd opcodes of the upper half pack register A into bits 11:10 and 14
    assign upperAddrEn = instruction[15] && instruction[12];
    assign regAAddr    = upperAddrEn ? {instruction[11:10], 1'b0, instruction[14]}
                                     : instruction[11:8];
    assign regANonZero = (regAAddr != 4'd0);

    always_comb begin
        dirtyEn     = 1'b0;
        fuEn        = 5'b00000;
        wbSrc       = decodePkg::WB_RESERVED;
        immEn       = 1'b0;
        upperImmEn  = 1'b0;
        regARead    = 1'b0;
        regAWrite   = 1'b0;
        regBRead    = 1'b0;
        stall       = 1'b0;
        jumpAndLink = 1'b0;
        pcEn        = 1'b0;
        if (instructionValid) begin
            case (majorOp)
                decodePkg::ALU0, decodePkg::ALU1: begin
                    regARead  = 1'b1;
                    regAWrite = 1'b1;
                    regBRead  = 1'b1;
                    if (majorOp == decodePkg::ALU0) begin
                        wbSrc = decodePkg::WB_ALU0_IMM;
                        fuEn  = 5'b00001;
                    end else begin
                        wbSrc = decodePkg::WB_ALU1;
                        fuEn  = 5'b00010;
                    end
                end
                decodePkg::COMPLEX, decodePkg::MEMORY: begin
                    regARead = 1'b1;
                    regBRead = 1'b1;
                    dirtyEn  = 1'b1;
                    fuEn     = (majorOp == decodePkg::COMPLEX) ? 5'b00100 : 5'b01000;
                end
                decodePkg::JAL_REG, decodePkg::JAL_IMM: begin
                    // Link always holds the pipe
                    pcEn        = 1'b1;
                    jumpAndLink = 1'b1;
                    stall       = 1'b1;
                    regARead    = 1'b1;
                    regAWrite   = 1'b1;
                    regBRead    = (majorOp == decodePkg::JAL_REG);
                    immEn       = (majorOp == decodePkg::JAL_IMM);
                    wbSrc       = decodePkg::WB_PC_PLUS_ONE;
                    fuEn        = 5'b10000;
                end
                decodePkg::BRANCH_REG, decodePkg::BRANCH_IMM: begin
                    // Conditional on register A, otherwise a plain jump
                    pcEn     = 1'b1;
                    stall    = regANonZero;
                    regARead = 1'b1;
                    regBRead = (majorOp == decodePkg::BRANCH_REG);
                    immEn    = (majorOp == decodePkg::BRANCH_IMM);
                    fuEn     = {regANonZero, 4'b0000};
                end
                decodePkg::UPPER_IMM: begin
                    regARead   = 1'b1;
                    regAWrite  = 1'b1;
                    immEn      = 1'b1;
                    upperImmEn = 1'b1;
                    wbSrc      = decodePkg::WB_ALU0_IMM;
                end
                decodePkg::IMM0, decodePkg::IMM1, decodePkg::IMM3: begin
                    regAWrite = 1'b1;
                    immEn     = 1'b1;
                    wbSrc     = decodePkg::WB_ALU0_IMM;
                end
                default: ;
            endcase
        end
    end

    assign jumpEn  = pcEn && !stall && !jumpAndLink;
    assign minorOp = immEn ? 4'h7 : instruction[7:4];

    // Jumps and branches always take the signed 10-bit form
    assign signExtend = jumpEn || fuEn[4];
    assign immSelect  = {instruction[13] || signExtend, instruction[12] || signExtend};
    assign wideImm    = signExtend ? {{(`DATA_WIDTH-10){instruction[9]}}, instruction[9:0]}
                                   : {{(`DATA_WIDTH-10){~pcEn}}, instruction[9:0]};

    always_comb begin
        case (immSelect)
            2'b01:   immediate = `DATA_WIDTH'(instruction[9:0]);
            2'b10:   immediate = `DATA_WIDTH'({instruction[7:0], 8'h00});
            2'b11:   immediate = wideImm;
            default: immediate = `DATA_WIDTH'(instruction[7:0]);
        endcase
    end

    always_comb begin
        decoded.dirtyBitTrigger  = dirtyEn && !minorOp[3] && !minorOp[2];
        decoded.funcUnitEnable   = fuEn;
        decoded.writebackSource  = wbSrc;
        decoded.minorOpcode      = minorOp;
        decoded.immediateEn      = immEn;
        decoded.upperImmediateEn = upperImmEn;
        decoded.immediate        = immediate;
        decoded.regAReadEn       = regARead;
        decoded.regAWriteEn      = regAWrite;
        decoded.regAAddr         = regAAddr;
        decoded.regBReadEn       = regBRead;
        decoded.regBAddr         = instruction[3:0];
        decoded.branchStall      = stall;
        decoded.relativeEn       = instruction[12];
        decoded.branchOffset     = `DATA_WIDTH'({instruction[7:4], 3'b000});
        decoded.jumpEn           = jumpEn;
        decoded.jumpAndLinkEn    = jumpAndLink;
        // Complex group, minor nibble F
        decoded.haltEn           = instructionValid &&
                                   ({instruction[15:12], instruction[7:4]} == 8'h2F);
    end

endmodule

// File: logic/InstructionQueue.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module InstructionQueue (
    input  logic          clk,
    input  logic          rst,
    instStreamIf.consumer inStream,
    instStreamIf.producer outStream
);
    localparam int Depth     = `QUEUE_DEPTH;
    localparam int AddrWidth = $clog2(Depth);

    logic [15:0]          instMem [Depth];
    logic [`PC_WIDTH-1:0] pcMem [Depth];

    // Top bit of each pointer is the wrap flag
    logic [AddrWidth:0] wrPtr;
    logic [AddrWidth:0] rdPtr;
    logic [AddrWidth:0] used;
    logic               full;
    logic               empty;
    logic               wrEn;
    logic               rdEn;

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[AddrWidth] != rdPtr[AddrWidth]) &&
                   (wrPtr[AddrWidth-1:0] == rdPtr[AddrWidth-1:0]);
    assign used  = wrPtr - rdPtr;

    assign inStream.ready = !full;
    assign wrEn           = inStream.valid && !full;

    // First word falls through to the output
    assign outStream.valid       = !empty;
    assign outStream.instruction = instMem[rdPtr[AddrWidth-1:0]];
    assign outStream.pc          = pcMem[rdPtr[AddrWidth-1:0]];
    assign rdEn                  = outStream.ready && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            instMem[wrPtr[AddrWidth-1:0]] <= inStream.instruction;
            pcMem[wrPtr[AddrWidth-1:0]]   <= inStream.pc;
        end
    end

    // Occupancy never passes the depth, so no write lands on a full queue
    noOverflow: assert property (@(posedge clk) disable iff (rst)
        used <= Depth);

    // Read pointer stays put while nothing is stored
    noUnderflow: assert property (@(posedge clk) disable iff (rst)
        empty && !wrEn |=> empty);

endmodule

// File: logic/FetchUnit.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module FetchUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instReq,
    input  logic [`DATA_WIDTH-1:0] instData,
    output logic                   instAck,
    instStreamIf.producer          outStream
);
    typedef enum logic {
        IDLE,
        ACKING
    } ackState_t;

    ackState_t            state;
    logic                 holdValid;
    logic [15:0]          holdWord;
    logic [`PC_WIDTH-1:0] holdPc;
    logic [`PC_WIDTH-1:0] pc;
    logic                 holdFree;
    logic                 capture;

    // Holding register can take a word when empty or draining this cycle
    assign holdFree = !holdValid || outStream.ready;
    assign capture  = (state == IDLE) && instReq && holdFree;

    assign instAck = (state == ACKING);

    assign outStream.valid       = holdValid;
    assign outStream.instruction = holdWord;
    assign outStream.pc          = holdPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            holdValid <= 1'b0;
            pc        <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (capture) begin
                        state <= ACKING;
                    end
                end
                ACKING: begin
                    // Wait for the source to drop its request
                    if (!instReq) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (capture) begin
                holdValid <= 1'b1;
                pc        <= pc + 1'b1;
            end else if (outStream.ready) begin
                holdValid <= 1'b0;
            end
        end
    end

    // Word and its tag
    always_ff @(posedge clk) begin
        if (capture) begin
            holdWord <= instData;
            holdPc   <= pc;
        end
    end

    ackOnlyWithReq: assert property (@(posedge clk) disable iff (rst)
        $rose(instAck) |-> instReq);

endmodule

// File: logic/instStreamIf.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

// Instruction word tagged with its program counter, valid/ready flow control
interface instStreamIf;
    logic                 valid;
    logic                 ready;
    logic [15:0]          instruction;
    logic [`PC_WIDTH-1:0] pc;

    modport producer (
        output valid,
        output instruction,
        output pc,
        input  ready
    );

    modport consumer (
        input  valid,
        input  instruction,
        input  pc,
        output ready
    );
endinterface

// File: logic/decodePkg.sv
`include "decode_defs.svh"

package decodePkg;

    // Top nibble of the instruction word
    typedef enum logic [3:0] {
        ALU0       = 4'd0,
        ALU1       = 4'd1,
        COMPLEX    = 4'd2,
        MEMORY     = 4'd3,
        JAL_REG    = 4'd8,
        JAL_IMM    = 4'd9,
        BRANCH_REG = 4'd10,
        BRANCH_IMM = 4'd11,
        IMM0       = 4'd12,
        IMM1       = 4'd13,
        UPPER_IMM  = 4'd14,
        IMM3       = 4'd15
    } majorOp_t;

    // Where the register A writeback comes from
    typedef enum logic [1:0] {
        WB_RESERVED    = 2'd0,
        WB_PC_PLUS_ONE = 2'd1,
        WB_ALU0_IMM    = 2'd2,
        WB_ALU1        = 2'd3
    } wbSource_t;

    typedef struct packed {
        logic                   dirtyBitTrigger;
        // One-hot: b0 ALU0, b1 ALU1, b2 complex, b3 memory, b4 branch
        logic [4:0]             funcUnitEnable;
        wbSource_t              writebackSource;
        logic [3:0]             minorOpcode;
        logic                   immediateEn;
        logic                   upperImmediateEn;
        logic [`DATA_WIDTH-1:0] immediate;
        logic                   regAReadEn;
        logic                   regAWriteEn;
        logic [3:0]             regAAddr;
        logic                   regBReadEn;
        logic [3:0]             regBAddr;
        logic                   branchStall;
        logic                   relativeEn;
        logic [`DATA_WIDTH-1:0] branchOffset;
        logic                   jumpEn;
        logic                   jumpAndLinkEn;
        logic                   haltEn;
    } decodedOp_t;

endpackage

// File: include/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Datapath width, also the immediate and branch offset width
`define DATA_WIDTH 16

// Program counter width
`define PC_WIDTH 8

// Queue entries, power of two
`define QUEUE_DEPTH 4

`endif
